// ==== ppuPkg.sv ====
package ppuPkg;

    // vectors with a meaning of their own
    typedef logic [9:0]  posType;        // raster coordinate
    typedef logic [11:0] rgbType;        // 4:4:4 colour
    typedef logic [5:0]  spriteIdxType;
    typedef logic [31:0] spriteWordType; // x[31:22] y[21:12] colour[11:0]
    typedef logic [10:0] ntAddrType;

    // 640x480 raster at 25 MHz pixel rate
    localparam int hActive = 640;
    localparam int hFront  = 16;
    localparam int hSync   = 96;
    localparam int hBack   = 48;
    localparam int hTotal  = hActive + hFront + hSync + hBack;

    localparam int vActive = 480;
    localparam int vFront  = 10;
    localparam int vSync   = 2;
    localparam int vBack   = 33;
    localparam int vTotal  = vActive + vFront + vSync + vBack;

    // game window, everything else is black
    localparam int winX0 = 64;
    localparam int winY0 = 32;
    localparam int winW  = 512;
    localparam int winH  = 416;

    // sprites
    localparam int spriteSize  = 16;
    localparam int spriteCount = 64;
    localparam int lineSlots   = 8;   // sprites kept per scan line

    // name table, one colour per 16x16 cell
    localparam int tileShift = 4;
    localparam int ntCols    = 40;
    localparam int ntRows    = 30;
    localparam int ntDepth   = ntCols * ntRows;

    // sprite colours that show the background instead
    localparam rgbType transpKeyA = 12'h000;
    localparam rgbType transpKeyB = 12'h209;

    // clocks from pixel presentation to the rgb pins
    localparam int pipeDepth = 2;

endpackage

// ==== vgaTiming.sv ====
`timescale 1ns/1ps

module vgaTiming (
    input  logic           clk_50MHz,
    input  logic           rstn,
    output logic           pixTick,
    output ppuPkg::posType pixX,
    output ppuPkg::posType pixY,
    output logic           inWindow,
    output logic           lineEnd,
    output logic           hsync,
    output logic           vsync
);
    import ppuPkg::*;

    logic                 tickPhase;
    logic                 hsyncNow;
    logic                 vsyncNow;
    logic [pipeDepth-1:0] hsyncPipe;
    logic [pipeDepth-1:0] vsyncPipe;

    // 25 MHz pixel rate, tick on the first clock out of reset
    always_ff @(posedge clk_50MHz) begin
        if (!rstn) begin
            tickPhase <= 1'b0;
        end else begin
            tickPhase <= ~tickPhase;
        end
    end

    assign pixTick = ~tickPhase;

    // vertical count steps at the hsync leading edge so vsync edges line up with it
    always_ff @(posedge clk_50MHz) begin
        if (!rstn) begin
            pixX <= '0;
            pixY <= '0;
        end else if (pixTick) begin
            if (pixX == posType'(hTotal - 1)) begin
                pixX <= '0;
            end else begin
                pixX <= pixX + 1'b1;
            end
            if (pixX == posType'(hActive + hFront - 1)) begin
                if (pixY == posType'(vTotal - 1)) begin
                    pixY <= '0;
                end else begin
                    pixY <= pixY + 1'b1;
                end
            end
        end
    end

    assign hsyncNow = !(pixX >= posType'(hActive + hFront) &&
                        pixX <  posType'(hActive + hFront + hSync));
    assign vsyncNow = !(pixY >= posType'(vActive + vFront) &&
                        pixY <  posType'(vActive + vFront + vSync));

    assign inWindow = (pixX >= posType'(winX0)) && (pixX < posType'(winX0 + winW)) &&
                      (pixY >= posType'(winY0)) && (pixY < posType'(winY0 + winH));

    assign lineEnd = pixTick && (pixX == posType'(hActive - 1)); // last visible pixel

    // syncs follow the colour pipeline
    always_ff @(posedge clk_50MHz) begin
        if (!rstn) begin
            hsyncPipe <= '1;
            vsyncPipe <= '1;
        end else begin
            hsyncPipe <= {hsyncPipe[pipeDepth-2:0], hsyncNow};
            vsyncPipe <= {vsyncPipe[pipeDepth-2:0], vsyncNow};
        end
    end

    assign hsync = hsyncPipe[pipeDepth-1];
    assign vsync = vsyncPipe[pipeDepth-1];

    tickAlternates: assert property (@(posedge clk_50MHz) disable iff (!rstn)
        pixTick |=> !pixTick);

    xInRange: assert property (@(posedge clk_50MHz) disable iff (!rstn)
        pixX < posType'(hTotal));

endmodule

// ==== backgroundEngine.sv ====
`timescale 1ns/1ps

module backgroundEngine (
    input  logic              clk_50MHz,
    input  logic              rstn,
    input  logic              ntWrEn,
    input  ppuPkg::ntAddrType ntWrAddr,
    input  ppuPkg::rgbType    ntWrData,
    input  ppuPkg::posType    pixX,
    input  ppuPkg::posType    pixY,
    output ppuPkg::rgbType    bgRgb
);
    import ppuPkg::*;

    rgbType    ntMem [ntDepth];
    logic      ntWe;
    posType    tileCol;
    posType    tileRow;
    logic      cellValid;
    ntAddrType cellAddr;

    // writes past the table end are dropped
    assign ntWe = ntWrEn && (ntWrAddr < ntAddrType'(ntDepth));

    always_ff @(posedge clk_50MHz) begin
        if (ntWe) begin
            ntMem[ntWrAddr] <= ntWrData;
        end
    end

    assign tileCol = pixX >> tileShift;
    assign tileRow = pixY >> tileShift;

    // blanking coordinates fall outside the table
    assign cellValid = (tileCol < posType'(ntCols)) && (tileRow < posType'(ntRows));

    always_comb begin
        cellAddr = '0;
        if (cellValid) begin
            cellAddr = ntAddrType'(tileRow) * ntAddrType'(ntCols) + ntAddrType'(tileCol);
        end
    end

    always_ff @(posedge clk_50MHz) begin
        if (!rstn) begin
            bgRgb <= '0;
        end else if (cellValid) begin
            bgRgb <= ntMem[cellAddr];
        end else begin
            bgRgb <= '0;
        end
    end

    outOfRangeIgnored: assert property (@(posedge clk_50MHz) disable iff (!rstn)
        (ntWrEn && ntWrAddr >= ntAddrType'(ntDepth)) |-> !ntWe);

endmodule

// ==== spriteEngine.sv ====
`timescale 1ns/1ps

module spriteEngine (
    input  logic                  clk_50MHz,
    input  logic                  rstn,
    input  logic                  spriteWrEn,
    input  ppuPkg::spriteIdxType  spriteWrAddr,
    input  ppuPkg::spriteWordType spriteWrData,
    input  ppuPkg::posType        pixX,
    input  ppuPkg::posType        pixY,
    input  logic                  lineEnd,
    output ppuPkg::rgbType        spRgb,
    output logic                  spHit
);
    import ppuPkg::*;

    typedef enum logic [1:0] {
        evalIdle,
        evalScan,
        evalDone
    } evalStateType;

    typedef logic [$clog2(lineSlots + 1)-1:0] slotCntType;
    typedef logic [$clog2(lineSlots)-1:0]     slotIdxType;

    spriteWordType attrMem [spriteCount];

    evalStateType  evalState;
    spriteIdxType  scanIdx;
    posType        evalLine;   // line being prepared
    slotCntType    slotCnt;

    posType        slotX   [lineSlots];
    rgbType        slotRgb [lineSlots];

    spriteWordType scanWord;
    posType        scanX;
    posType        scanY;
    rgbType        scanRgb;
    logic          scanCovers;
    logic          scanOpaque;
    logic          slotTake;

    logic          hitNext;
    rgbType        rgbNext;

    // attribute RAM, CPU side
    always_ff @(posedge clk_50MHz) begin
        if (spriteWrEn) begin
            attrMem[spriteWrAddr] <= spriteWrData;
        end
    end

    assign scanWord = attrMem[scanIdx];
    assign scanX    = scanWord[31:22];
    assign scanY    = scanWord[21:12];
    assign scanRgb  = scanWord[11:0];

    // does the sprite's 16 rows include evalLine
    assign scanCovers = ({1'b0, evalLine} >= {1'b0, scanY}) &&
                        ({1'b0, evalLine} < {1'b0, scanY} + 11'(spriteSize));
    assign scanOpaque = (scanRgb != transpKeyA) && (scanRgb != transpKeyB);

    assign slotTake = (evalState == evalScan) && scanCovers && scanOpaque &&
                      (slotCnt < slotCntType'(lineSlots));

    // one attribute word per clock during horizontal blanking
    always_ff @(posedge clk_50MHz) begin
        if (!rstn) begin
            evalState <= evalIdle;
            scanIdx   <= '0;
            evalLine  <= '0;
            slotCnt   <= '0;
        end else begin
            case (evalState)
                evalIdle: begin
                    if (lineEnd) begin
                        if (pixY == posType'(vTotal - 1)) begin
                            evalLine <= '0;  // wrap to top of frame
                        end else begin
                            evalLine <= pixY + 1'b1;
                        end
                        scanIdx   <= '0;
                        slotCnt   <= '0;
                        evalState <= evalScan;
                    end
                end
                evalScan: begin
                    if (slotTake) begin
                        slotCnt <= slotCnt + 1'b1;
                    end
                    if (scanIdx == spriteIdxType'(spriteCount - 1)) begin
                        evalState <= evalDone;
                    end
                    scanIdx <= scanIdx + 1'b1;
                end
                evalDone: begin
                    evalState <= evalIdle;
                end
                default: begin
                    evalState <= evalIdle;
                end
            endcase
        end
    end

    // slots fill in index order
    always_ff @(posedge clk_50MHz) begin
        if (slotTake) begin
            slotX[slotIdxType'(slotCnt)]   <= scanX;
            slotRgb[slotIdxType'(slotCnt)] <= scanRgb;
        end
    end

    // lowest slot wins, so walk down from the top
    always_comb begin
        hitNext = 1'b0;
        rgbNext = '0;
        for (int i = lineSlots - 1; i >= 0; i--) begin
            if ((slotCntType'(i) < slotCnt) &&
                ({1'b0, pixX} >= {1'b0, slotX[i]}) &&
                ({1'b0, pixX} < {1'b0, slotX[i]} + 11'(spriteSize))) begin
                hitNext = 1'b1;
                rgbNext = slotRgb[i];
            end
        end
    end

    always_ff @(posedge clk_50MHz) begin
        if (!rstn) begin
            spHit <= 1'b0;
        end else begin
            spHit <= hitNext;
        end
    end

    always_ff @(posedge clk_50MHz) begin
        spRgb <= rgbNext;
    end

    slotLimit: assert property (@(posedge clk_50MHz) disable iff (!rstn)
        slotCnt <= slotCntType'(lineSlots));

    // previous line's evaluation is over before the next one is due
    evalInTime: assert property (@(posedge clk_50MHz) disable iff (!rstn)
        lineEnd |-> evalState == evalIdle);

endmodule

// ==== ppuTop.sv ====
`timescale 1ns/1ps

module ppuTop (
    input  logic                  clk_50MHz,
    input  logic                  rstn,
    input  logic                  spriteWrEn,
    input  ppuPkg::spriteIdxType  spriteWrAddr,
    input  ppuPkg::spriteWordType spriteWrData,
    input  logic                  ntWrEn,
    input  ppuPkg::ntAddrType     ntWrAddr,
    input  ppuPkg::rgbType        ntWrData,
    output logic                  hsync,
    output logic                  vsync,
    output ppuPkg::rgbType        rgb,
    output logic                  frameIrq
);
    import ppuPkg::*;

    posType pixX;
    posType pixY;
    logic   inWindow;
    logic   lineEnd;
    rgbType bgRgb;
    rgbType spRgb;
    logic   spHit;

    posType pixXD;     // coordinates aligned with engine outputs
    posType pixYD;
    logic   winD;
    logic   spVisible;
    rgbType pixSel;
    logic   lastPix;
    logic   lastPixR;
    logic   lastPixRR;

    vgaTiming uVgaTiming (
        .clk_50MHz (clk_50MHz),
        .rstn      (rstn),
        .pixTick   (),
        .pixX      (pixX),
        .pixY      (pixY),
        .inWindow  (inWindow),
        .lineEnd   (lineEnd),
        .hsync     (hsync),
        .vsync     (vsync)
    );

    backgroundEngine uBackgroundEngine (
        .clk_50MHz (clk_50MHz),
        .rstn      (rstn),
        .ntWrEn    (ntWrEn),
        .ntWrAddr  (ntWrAddr),
        .ntWrData  (ntWrData),
        .pixX      (pixX),
        .pixY      (pixY),
        .bgRgb     (bgRgb)
    );

    spriteEngine uSpriteEngine (
        .clk_50MHz    (clk_50MHz),
        .rstn         (rstn),
        .spriteWrEn   (spriteWrEn),
        .spriteWrAddr (spriteWrAddr),
        .spriteWrData (spriteWrData),
        .pixX         (pixX),
        .pixY         (pixY),
        .lineEnd      (lineEnd),
        .spRgb        (spRgb),
        .spHit        (spHit)
    );

    always_ff @(posedge clk_50MHz) begin
        if (!rstn) begin
            winD <= 1'b0;
        end else begin
            winD <= inWindow;
        end
    end

    always_ff @(posedge clk_50MHz) begin
        pixXD <= pixX;
        pixYD <= pixY;
    end

    assign spVisible = spHit && (spRgb != transpKeyA) && (spRgb != transpKeyB);

    always_comb begin
        if (!winD) begin
            pixSel = '0;
        end else if (spVisible) begin
            pixSel = spRgb;
        end else begin
            pixSel = bgRgb;
        end
    end

    always_ff @(posedge clk_50MHz) begin
        if (!rstn) begin
            rgb <= '0;
        end else begin
            rgb <= pixSel;
        end
    end

    // last window pixel, seen at engine output time
    assign lastPix = (pixXD == posType'(winX0 + winW - 1)) &&
                     (pixYD == posType'(winY0 + winH - 1));

    always_ff @(posedge clk_50MHz) begin
        if (!rstn) begin
            lastPixR  <= 1'b0;
            lastPixRR <= 1'b0;
            frameIrq  <= 1'b0;
        end else begin
            lastPixR  <= lastPix;
            lastPixRR <= lastPixR;
            frameIrq  <= lastPixR & ~lastPixRR; // one clock after the pixel hits the pins
        end
    end

endmodule

// ==== tbPpu.sv ====
`timescale 1ns/1ps

module tbPpu;
    import ppuPkg::*;

    localparam int resetCycles = 16;
    localparam int cycleLimit  = resetCycles + 3 * hTotal * vTotal * 2;
    localparam int irqClock    = 2 * (hBack + winX0 + winW - 1) + 1;
    localparam int irqLine     = winY0 + winH - 1;
    localparam spriteWordType parkWord = {10'd0, 10'd1000, 12'h000}; // below the raster

    logic          clk_50MHz;
    logic          rstn;
    logic          spriteWrEn;
    spriteIdxType  spriteWrAddr;
    spriteWordType spriteWrData;
    logic          ntWrEn;
    ntAddrType     ntWrAddr;
    rgbType        ntWrData;
    logic          hsync;
    logic          vsync;
    rgbType        rgb;
    logic          frameIrq;

    int           seed;
    int           cycleCnt;
    logic [7:0]   portQ [$];
    int           addrQ [$];
    logic [31:0]  dataQ [$];
    rgbType       expRgb [int];   // key is frame, y, x
    logic         hsyncPrev;
    logic         vsyncPrev;
    int           hCnt;
    int           lineCnt;
    int           frameNo;
    int           irqPulses;
    int           rgbChecks;
    int           rgbErrors;
    int           syncErrors;
    int           irqErrors;
    int           otherErrors;

    ppuTop i_ppuTop (
        .clk_50MHz    (clk_50MHz),
        .rstn         (rstn),
        .spriteWrEn   (spriteWrEn),
        .spriteWrAddr (spriteWrAddr),
        .spriteWrData (spriteWrData),
        .ntWrEn       (ntWrEn),
        .ntWrAddr     (ntWrAddr),
        .ntWrData     (ntWrData),
        .hsync        (hsync),
        .vsync        (vsync),
        .rgb          (rgb),
        .frameIrq     (frameIrq)
    );

    initial begin
        clk_50MHz = 1'b0;
        forever #10 clk_50MHz = ~clk_50MHz;
    end

    function automatic bit loadGolden();
        int          fd;
        int          code;
        int          f;
        int          x;
        int          y;
        logic [7:0]  tag;
        logic [7:0]  port;
        logic [31:0] addr;
        logic [31:0] data;
        logic [8*160-1:0] skipLine;
        fd = $fopen("ppuGolden.txt", "r");
        if (fd == 0) begin
            return 1'b0;
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "#") begin
                code = $fgets(skipLine, fd);
            end else if (tag == "W") begin
                code = $fscanf(fd, "%s %h %h", port, addr, data);
                portQ.push_back(port);
                addrQ.push_back(int'(addr));
                dataQ.push_back(data);
            end else if (tag == "C") begin
                code = $fscanf(fd, "%d %d %d %h", f, x, y, data);
                expRgb[f * 1000000 + y * 1000 + x] = rgbType'(data);
            end else begin
                $display("golden file holds a record of unknown kind");
                otherErrors++;
            end
        end
        $fclose(fd);
        return 1'b1;
    endfunction

    task automatic writeSprite(input int idx, input spriteWordType word);
        spriteWrEn   = 1'b1;
        spriteWrAddr = spriteIdxType'(idx);
        spriteWrData = word;
        @(negedge clk_50MHz);
        spriteWrEn   = 1'b0;
    endtask

    task automatic writeName(input int addr, input rgbType data);
        ntWrEn   = 1'b1;
        ntWrAddr = ntAddrType'(addr);
        ntWrData = data;
        @(negedge clk_50MHz);
        ntWrEn   = 1'b0;
    endtask

    task automatic checkRgb(input string where, input rgbType expected, input rgbType actual);
        if (actual !== expected) begin
            $display("ERR rgb %s expected %h got %h", where, expected, actual);
            rgbErrors++;
        end
    endtask

    task automatic checkSync(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h got %h", name, expected, actual);
            syncErrors++;
        end
    endtask

    task automatic checkIrq(input string where, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERR frameIrq %s expected %h got %h", where, expected, actual);
            irqErrors++;
        end
    endtask

    task automatic reportAndFinish();
        int errors;
        if (irqPulses != 2) begin
            $display("frameIrq pulsed %0d times over two frames instead of 2", irqPulses);
            irqErrors++;
        end
        if (rgbChecks != expRgb.num()) begin
            $display("only %0d of %0d pixel checks were reached", rgbChecks, expRgb.num());
            otherErrors++;
        end
        errors = rgbErrors + syncErrors + irqErrors + otherErrors;
        $display("rgb checks %0d, errors: rgb %0d sync %0d irq %0d other %0d",
                 rgbChecks, rgbErrors, syncErrors, irqErrors, otherErrors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    initial begin
        bit goldenOk;
        rstn         = 1'b0;
        spriteWrEn   = 1'b0;
        spriteWrAddr = '0;
        spriteWrData = '0;
        ntWrEn       = 1'b0;
        ntWrAddr     = '0;
        ntWrData     = '0;
        seed         = 32'h42961ac4;
        cycleCnt     = 0;
        hsyncPrev    = 1'b1;
        vsyncPrev    = 1'b1;
        hCnt         = 0;
        lineCnt      = 0;
        frameNo      = 0;
        irqPulses    = 0;
        rgbChecks    = 0;
        rgbErrors    = 0;
        syncErrors   = 0;
        irqErrors    = 0;
        otherErrors  = 0;
        goldenOk = loadGolden();
        if (!goldenOk) begin
            $display("cannot open ppuGolden.txt for reading");
            $display("FAIL: see errors above");
            $finish;
        end else begin
            repeat (resetCycles) @(negedge clk_50MHz);
            rstn = 1'b1;
            for (int i = 0; i < spriteCount; i++) begin
                writeSprite(i, parkWord);
            end
            // random colours for cells nobody checks
            for (int a = 0; a < ntDepth; a++) begin
                writeName(a, rgbType'($random(seed)));
            end
            foreach (portQ[i]) begin
                if (portQ[i] == "S") begin
                    writeSprite(addrQ[i], spriteWordType'(dataQ[i]));
                end else begin
                    writeName(addrQ[i], rgbType'(dataQ[i]));
                end
            end
        end
    end

    always @(posedge clk_50MHz) begin
        cycleCnt = cycleCnt + 1;
        if (cycleCnt >= cycleLimit) begin
            $display("timeout: frame 2 did not end within %0d cycles", cycleLimit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // outputs held in reset
    always @(negedge clk_50MHz) begin
        if (cycleCnt >= 1 && cycleCnt < resetCycles) begin
            checkSync("hsync", 1'b1, hsync);
            checkSync("vsync", 1'b1, vsync);
            checkRgb("in reset", 12'h000, rgb);
            checkIrq("in reset", 1'b0, frameIrq);
        end
    end

    always @(negedge clk_50MHz) begin : trackRaster
        int   x;
        int   y;
        int   key;
        logic irqDue;
        if (cycleCnt > resetCycles) begin
            if (hsync && !hsyncPrev) begin
                hCnt    = 0;
                lineCnt = lineCnt + 1;
            end else begin
                hCnt = hCnt + 1;
            end
            if (vsync && !vsyncPrev) begin
                frameNo = frameNo + 1;
                lineCnt = 0;
            end
            hsyncPrev = hsync;
            vsyncPrev = vsync;
            x = (hCnt - 1) / 2 - hBack;   // valid on odd hCnt
            y = lineCnt - vBack - 1;
            irqDue = (y == irqLine) && (hCnt == irqClock);
            if (frameNo >= 3) begin
                reportAndFinish();
            end else if (frameNo >= 1) begin
                key = frameNo * 1000000 + y * 1000 + x;
                if (hCnt[0] && x >= 0 && x < hActive && y >= 0 && expRgb.exists(key)) begin
                    checkRgb($sformatf("x=%0d y=%0d", x, y), expRgb[key], rgb);
                    rgbChecks++;
                end
                if (frameIrq) begin
                    irqPulses++;
                end
                if (frameIrq && !irqDue) begin
                    $display("frameIrq pulse at clock %0d of line %0d in frame %0d is out of place",
                             hCnt, y, frameNo);
                    irqErrors++;
                end else if (irqDue && !frameIrq) begin
                    $display("frameIrq missing after the last window pixel in frame %0d", frameNo);
                    irqErrors++;
                end
            end
        end
    end

endmodule

// ==== ppuGolden.txt ====
# W port addr data: port S sprite word, N name-table cell, addr and data in hex
# C frame x y rgb: frame, x and y in decimal, expected rgb in hex
W N 0A8 3A5
W N 19A 7E2
W N 02A ABC
W N 45B 1F3
W N 32C 9D0
W N 32D 6A6
W S 01 240420F0
W S 03 22042F00
W S 05 20046209
W S 06 0C064FFF
W S 14 1013C801
W S 15 1413C802
W S 16 1813C803
W S 17 1C13C804
W S 18 2013C805
W S 19 2413C806
W S 1A 2813C807
W S 1B 2C13C808
W S 1C 3013C809
W S 1D 3413C80A
C 2 130 72 3A5
C 2 140 72 F00
C 2 148 72 0F0
C 2 152 72 0F0
C 2 165 170 7E2
C 2 70 324 801
C 2 190 324 808
C 2 200 324 9D0
C 2 215 324 6A6
C 2 40 20 000
C 2 50 104 000
C 2 575 447 1F3
C 2 576 447 000

// ==== filelist.f ====
ppuPkg.sv
vgaTiming.sv
backgroundEngine.sv
spriteEngine.sv
ppuTop.sv
tbPpu.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tbPpu -f filelist.f -o simPpu
./obj_dir/simPpu | tee sim.log

if grep -qx "PASS: all tests" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
